//--- Bender.yml
package:
  name: m6502

sources:
  - files:
      - verilog/m6502_pkg.sv
      - verilog/m6502_decoder.sv
      - verilog/m6502_alu.sv
      - verilog/m6502_bus_ctrl.sv
      - verilog/m6502_sequencer.sv
      - verilog/m6502_cpu.sv
  - target: simulation
    files:
      - bench/m6502_mem_model.sv
      - bench/tb_m6502.sv

//--- bench/m6502_mem_model.sv
// --------------------------------------------------
// 64 KiB byte memory for the core testbench. Reads are
// combinational, ready_i stalls are random.
// --------------------------------------------------
module m6502_mem_model #(
   parameter int SEED = 1
) (
   input  logic             clk,
   input  logic [1:0]       stall_mode_i,  // 0 random, 1 always ready, 2 long stalls
   input  m6502_pkg::addr_t addr_i,
   input  logic             rd_req_i,
   input  logic             wr_en_i,
   input  m6502_pkg::byte_t wr_data_i,
   output m6502_pkg::byte_t rd_data_o,
   output logic             ready_o
);
   timeunit 1ns;
   timeprecision 100ps;

   m6502_pkg::byte_t mem [0:65535];
   m6502_pkg::addr_t wr_addr_q[$];
   m6502_pkg::byte_t wr_data_q[$];
   m6502_pkg::addr_t rd_addr_q[$];
   int               stall_left;
   logic [31:0]      rnd;

   assign rd_data_o = (rd_req_i === 1'b1) ? mem[addr_i] : 8'h00;

   task automatic fill_pattern();
      for (int a = 0; a < 65536; a++)
         mem[a] = a[15:8] ^ a[7:0] ^ 8'hA5;
   endtask

   task automatic load_byte(input m6502_pkg::addr_t addr, input m6502_pkg::byte_t data);
      mem[addr] = data;
   endtask

   task automatic clear_logs();
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
   endtask

   function automatic int write_count();
      return wr_addr_q.size();
   endfunction

   function automatic m6502_pkg::addr_t write_addr(input int i);
      return wr_addr_q[i];
   endfunction

   function automatic m6502_pkg::byte_t write_data(input int i);
      return wr_data_q[i];
   endfunction

   function automatic m6502_pkg::addr_t read_addr(input int i);
      return rd_addr_q[i];
   endfunction

   // Ready changes on the falling edge only
   initial
   begin
      void'($urandom(SEED));
      ready_o    = 1'b0;
      stall_left = 0;
      fill_pattern();
      forever
      begin
         @(negedge clk);
         rnd = $urandom;
         if (stall_mode_i == 2'd1)
            ready_o = 1'b1;
         else if (stall_left > 0)
         begin
            ready_o    = 1'b0;
            stall_left = stall_left - 1;
         end
         else if (stall_mode_i == 2'd2)
         begin
            ready_o = (rnd[1:0] != 2'b00);
            if (rnd[1:0] == 2'b00)
               stall_left = rnd[4:2];  // Up to 8 cycles low
         end
         else
            ready_o = (rnd[1:0] != 2'b00);
      end
   end

   always @(posedge clk)
   begin
      if (wr_en_i && ready_o)
      begin
         mem[addr_i] <= wr_data_i;
         wr_addr_q.push_back(addr_i);
         wr_data_q.push_back(wr_data_i);
      end
      if (rd_req_i && ready_o)
         rd_addr_q.push_back(addr_i);
   end

endmodule

//--- bench/tb_m6502.sv
// --------------------------------------------------
// Directed testbench for the 6502-style core. Each test
// loads a program and checks the logged memory writes.
// --------------------------------------------------
module tb_m6502;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int               SEED           = 16864;
   localparam int               CLK_PERIOD     = 4;
   localparam m6502_pkg::addr_t VEC_ADDR       = 16'hFFF0;
   localparam m6502_pkg::addr_t MARKER         = 16'h00FF;
   localparam int               NUM_RUNS       = 13;
   localparam int               CYCLES_PER_RUN = 2000;

   logic             clk;
   logic             reset_n;
   logic [1:0]       stall_mode;
   m6502_pkg::addr_t addr;
   m6502_pkg::byte_t rd_data;
   m6502_pkg::byte_t wr_data;
   logic             wr_en;
   logic             rd_req;
   logic             ready;

   m6502_pkg::addr_t prog_ptr;
   m6502_pkg::addr_t prog_start;
   m6502_pkg::byte_t model_acc;
   logic             model_c;
   m6502_pkg::addr_t exp_addr[$];
   m6502_pkg::byte_t exp_data[$];

   initial
      clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   m6502_cpu #(
      .RESET_VECTOR (VEC_ADDR)
   ) DUT (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (addr),
      .rd_data_i (rd_data),
      .wr_data_o (wr_data),
      .wr_en_o   (wr_en),
      .rd_req_o  (rd_req),
      .ready_i   (ready)
   );

   m6502_mem_model #(
      .SEED (SEED)
   ) u_mem (
      .clk          (clk),
      .stall_mode_i (stall_mode),
      .addr_i       (addr),
      .rd_req_i     (rd_req),
      .wr_en_i      (wr_en),
      .wr_data_i    (wr_data),
      .rd_data_o    (rd_data),
      .ready_o      (ready)
   );

   task automatic check_equal(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
      begin
         $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         $display("TESTS FAILED");
         $fatal(1);
      end
   endtask

   // Bit by bit sum, carry out in bit 8
   function automatic logic [8:0] add_with_carry(input m6502_pkg::byte_t a,
                                                 input m6502_pkg::byte_t b, input logic cin);
      logic             c;
      m6502_pkg::byte_t s;
      c = cin;
      for (int i = 0; i < 8; i++)
      begin
         s[i] = a[i] ^ b[i] ^ c;
         c    = (a[i] & b[i]) | (c & (a[i] ^ b[i]));
      end
      return {c, s};
   endfunction

   function automatic m6502_pkg::byte_t bitwise_result(input int op, input m6502_pkg::byte_t a,
                                                       input m6502_pkg::byte_t b);
      case (op)
         0:       return a | b;
         1:       return a & b;
         default: return a ^ b;
      endcase
   endfunction

   function automatic bit marker_written();
      for (int i = 0; i < u_mem.write_count(); i++)
         if (u_mem.write_addr(i) == MARKER)
            return 1'b1;
      return 1'b0;
   endfunction

   task automatic emit(input m6502_pkg::byte_t b);
      u_mem.load_byte(prog_ptr, b);
      prog_ptr = prog_ptr + 16'd1;
   endtask

   // Group one opcode with bbb = 000, mode 0 IMM, 1 ZP, 2 ABS
   task automatic emit_op(input m6502_pkg::byte_t base, input int mode,
                          input m6502_pkg::byte_t value, input int slot);
      m6502_pkg::addr_t abs_addr;
      abs_addr = 16'h4100 + slot[15:0];
      if (mode == 0)
      begin
         emit(base | 8'h08);
         emit(value);
      end
      else if (mode == 1)
      begin
         u_mem.load_byte(16'h0080 + slot[15:0], value);
         emit(base | 8'h04);
         emit(8'h80 + slot[7:0]);
      end
      else
      begin
         u_mem.load_byte(abs_addr, value);
         emit(base | 8'h0C);
         emit(abs_addr[7:0]);
         emit(abs_addr[15:8]);
      end
   endtask

   task automatic emit_store(input m6502_pkg::addr_t a);
      if (a[15:8] == 8'h00)
      begin
         emit(8'h85);
         emit(a[7:0]);
      end
      else
      begin
         emit(8'h8D);
         emit(a[7:0]);
         emit(a[15:8]);
      end
      exp_addr.push_back(a);
      exp_data.push_back(model_acc);
   endtask

   task automatic do_lda(input m6502_pkg::byte_t value);
      emit_op(8'hA1, 0, value, 0);
      model_acc = value;
   endtask

   task automatic do_arith(input bit sub, input int mode, input m6502_pkg::byte_t value,
                           input int slot);
      emit_op(sub ? 8'hE1 : 8'h61, mode, value, slot);
      {model_c, model_acc} = add_with_carry(model_acc, sub ? ~value : value, model_c);
   endtask

   task automatic do_cmp(input int mode, input m6502_pkg::byte_t value, input int slot);
      emit_op(8'hC1, mode, value, slot);
      model_c = (model_acc >= value);
   endtask

   // sel 0 N, 1 V, 2 C, 3 Z, as in opcode bits 7:6
   task automatic set_flag(input int sel, input bit value);
      case (sel)
         0: do_lda(value ? 8'h80 : 8'h01);
         1:
         begin
            do_lda(value ? 8'h50 : 8'h01);
            do_cmp(0, value ? 8'h60 : 8'h01, 0);
            do_arith(1'b0, 0, value ? 8'h50 : 8'h01, 0);
         end
         2:
         begin
            do_lda(8'h10);
            do_cmp(0, value ? 8'h10 : 8'h20, 0);
         end
         default: do_lda(value ? 8'h00 : 8'h01);
      endcase
   endtask

   task automatic hold_reset();
      @(negedge clk);
      reset_n = 1'b0;
      repeat (3)
      begin
         @(negedge clk);
         check_equal("rd_req_o in reset", 16'd0, {15'd0, rd_req});
         check_equal("wr_en_o in reset", 16'd0, {15'd0, wr_en});
      end
   endtask

   task automatic begin_program(input m6502_pkg::addr_t start);
      hold_reset();
      u_mem.fill_pattern();
      u_mem.load_byte(VEC_ADDR, start[7:0]);
      u_mem.load_byte(VEC_ADDR + 16'd1, start[15:8]);
      prog_start = start;
      prog_ptr   = start;
      model_acc  = 8'h00;  // Core state after reset
      model_c    = 1'b0;
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic run_program();
      emit_store(MARKER);
      u_mem.clear_logs();
      reset_n = 1'b1;
      while (!marker_written())
         @(negedge clk);
      check_equal("vector low read addr_o", VEC_ADDR, u_mem.read_addr(0));
      check_equal("vector high read addr_o", VEC_ADDR + 16'd1, u_mem.read_addr(1));
      check_equal("first fetch addr_o", prog_start, u_mem.read_addr(2));
      check_equal("write count", exp_addr.size(), u_mem.write_count());
      for (int i = 0; i < exp_addr.size(); i++)
      begin
         check_equal($sformatf("write %0d addr_o", i), exp_addr[i], u_mem.write_addr(i));
         check_equal($sformatf("write %0d wr_data_o", i), {8'd0, exp_data[i]},
                     {8'd0, u_mem.write_data(i)});
      end
   endtask

   task automatic test_reset_vector();
      begin_program(16'hC123);
      emit(8'hEA);  // No-op
      do_lda(8'h5A);
      run_program();
   endtask

   task automatic test_load_store();
      begin_program(16'h0300);
      do_lda(8'hC3);
      emit_store(16'h0040);
      emit_store(16'h1234);
      do_lda(8'h00);
      emit_store(16'h2ABC);
      emit_op(8'hA1, 1, 8'h7E, 1);
      model_acc = 8'h7E;
      emit_store(16'h0041);
      emit_op(8'hA1, 2, 8'h81, 2);
      model_acc = 8'h81;
      emit_store(16'h3FFF);
      run_program();
   endtask

   task automatic test_logic();
      m6502_pkg::byte_t a;
      m6502_pkg::byte_t b;
      int               k;
      begin_program(16'h0400);
      for (int op = 0; op < 3; op++)
         for (int mode = 0; mode < 3; mode++)
         begin
            k = op * 3 + mode;
            a = 8'h5A ^ (k[7:0] * 8'h37);
            b = 8'hC3 + k[7:0] * 8'h1D;
            do_lda(a);
            emit_op({op[2:0], 5'b00001}, mode, b, k);
            model_acc = bitwise_result(op, a, b);
            emit_store(16'h0020 + k[15:0]);
         end
      run_program();
   endtask

   task automatic test_arith();
      begin_program(16'h0500);
      do_lda(8'h70);
      do_arith(1'b0, 0, 8'h95, 0);  // Carry out
      emit_store(16'h0020);
      do_arith(1'b0, 1, 8'hFF, 1);
      emit_store(16'h0021);
      do_lda(8'h50);
      do_arith(1'b1, 2, 8'h20, 2);
      emit_store(16'h0022);
      do_arith(1'b1, 0, 8'h40, 3);  // Borrow
      emit_store(16'h0023);
      do_arith(1'b1, 0, 8'h10, 4);
      emit_store(16'h0024);
      do_cmp(0, 8'hE0, 5);
      do_arith(1'b0, 0, 8'h01, 6);
      emit_store(16'h0025);
      do_cmp(1, 8'h20, 7);
      do_lda(8'h10);
      do_arith(1'b0, 2, 8'h10, 8);
      emit_store(16'h0026);
      do_cmp(2, model_acc, 9);  // Equal sets carry
      do_arith(1'b0, 0, 8'h00, 10);
      emit_store(16'h0027);
      run_program();
   endtask

   task automatic test_branches();
      m6502_pkg::byte_t opc;
      int               sel;
      bit               take_val;
      begin_program(16'h0600);
      for (int k = 0; k < 8; k++)
      begin
         opc      = {k[2:0], 5'b10000};
         sel      = k / 2;
         take_val = k[0];
         set_flag(sel, take_val);
         emit(opc);
         emit(8'h02);
         emit(8'h85);
         emit(8'h60 + k[7:0]);  // Skipped when taken
         emit_store(16'h0040 + k[15:0]);
         set_flag(sel, !take_val);
         emit(opc);
         emit(8'h02);
         emit_store(16'h0048 + k[15:0]);
         emit(opc);
         emit(8'hFA);  // Backward, not taken
         set_flag(sel, take_val);
         emit(opc);
         emit(8'h04);
         emit_store(16'h0050 + k[15:0]);  // Reached only by the backward branch
         emit(opc);
         emit(8'h02);
         emit(opc);
         emit(8'hFA);
      end
      run_program();
   endtask

   initial
   begin
      #(NUM_RUNS * CYCLES_PER_RUN * CLK_PERIOD);
      $display("Timeout: the tests did not finish within %0d clock cycles",
               NUM_RUNS * CYCLES_PER_RUN);
      $display("TESTS FAILED");
      $fatal(1);
   end

   initial
   begin
      reset_n    = 1'b0;
      stall_mode = 2'd0;
      test_reset_vector();
      for (int m = 0; m < 3; m++)
      begin
         stall_mode = m[1:0];  // Random, always ready, long stalls
         test_load_store();
         test_logic();
         test_arith();
         test_branches();
      end
      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- project.f
verilog/m6502_pkg.sv
verilog/m6502_decoder.sv
verilog/m6502_alu.sv
verilog/m6502_bus_ctrl.sv
verilog/m6502_sequencer.sv
verilog/m6502_cpu.sv
bench/m6502_mem_model.sv
bench/tb_m6502.sv

//--- verilog/m6502_alu.sv
// --------------------------------------------------
// Accumulator, N/V/Z/C flags and the arithmetic and
// logic unit. Updates on the edge after alu_go_i.
// --------------------------------------------------
module m6502_alu (
   input  logic               clk,
   input  logic               reset_n,
   input  logic               alu_go_i,
   input  m6502_pkg::cpu_op_e alu_op_i,
   input  m6502_pkg::byte_t   alu_operand_i,
   output m6502_pkg::byte_t   acc_o,
   output m6502_pkg::flags_t  flags_o
);

   m6502_pkg::byte_t b;
   m6502_pkg::byte_t logic_res;
   logic             carry_in;
   logic [8:0]       sum;
   logic             ovf;

   // SBC and CMP add the inverted operand
   assign b        = (alu_op_i == m6502_pkg::ADC) ? alu_operand_i : ~alu_operand_i;
   assign carry_in = (alu_op_i == m6502_pkg::CMP) ? 1'b1 : flags_o[m6502_pkg::FLAG_C];
   assign sum      = {1'b0, acc_o} + {1'b0, b} + {8'd0, carry_in};
   assign ovf      = (acc_o[7] == b[7]) && (sum[7] != acc_o[7]);

   always_comb
   begin
      case (alu_op_i)
         m6502_pkg::ORA: logic_res = acc_o | alu_operand_i;
         m6502_pkg::AND: logic_res = acc_o & alu_operand_i;
         m6502_pkg::EOR: logic_res = acc_o ^ alu_operand_i;
         default:        logic_res = alu_operand_i;  // LDA
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         acc_o   <= 8'h00;
         flags_o <= 4'h0;
      end
      else if (alu_go_i)
      begin
         case (alu_op_i)
            m6502_pkg::ORA, m6502_pkg::AND, m6502_pkg::EOR, m6502_pkg::LD:
            begin
               acc_o                      <= logic_res;
               flags_o[m6502_pkg::FLAG_N] <= logic_res[7];
               flags_o[m6502_pkg::FLAG_Z] <= (logic_res == 8'h00);
            end
            m6502_pkg::ADC, m6502_pkg::SBC:
            begin
               acc_o                      <= sum[7:0];
               flags_o[m6502_pkg::FLAG_N] <= sum[7];
               flags_o[m6502_pkg::FLAG_V] <= ovf;
               flags_o[m6502_pkg::FLAG_Z] <= (sum[7:0] == 8'h00);
               flags_o[m6502_pkg::FLAG_C] <= sum[8];
            end
            m6502_pkg::CMP:
            begin
               flags_o[m6502_pkg::FLAG_N] <= sum[7];
               flags_o[m6502_pkg::FLAG_Z] <= (sum[7:0] == 8'h00);
               flags_o[m6502_pkg::FLAG_C] <= sum[8];  // A >= operand
            end
            default:
               ;
         endcase
      end
   end

endmodule

//--- verilog/m6502_bus_ctrl.sv
// --------------------------------------------------
// Memory port controller. Runs vector, fetch and
// operand accesses, holding each until ready_i.
// --------------------------------------------------
module m6502_bus_ctrl #(
   parameter m6502_pkg::addr_t RESET_VECTOR = m6502_pkg::RESET_VECTOR_DEF
) (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  vec_start_i,
   output logic                  vec_done_o,
   output m6502_pkg::addr_t      vec_addr_o,
   input  logic                  fetch_start_i,
   input  m6502_pkg::addr_t      fetch_addr_i,
   output logic                  fetch_done_o,
   output m6502_pkg::byte_t      fetch_data_o,
   input  logic                  opnd_start_i,
   input  m6502_pkg::addr_mode_e opnd_mode_i,
   input  m6502_pkg::addr_t      opnd_pc_i,
   input  logic                  opnd_store_i,
   output logic                  opnd_done_o,
   output m6502_pkg::byte_t      opnd_data_o,
   input  m6502_pkg::byte_t      store_data_i,
   output m6502_pkg::addr_t      addr_o,
   input  m6502_pkg::byte_t      rd_data_i,
   output m6502_pkg::byte_t      wr_data_o,
   output logic                  wr_en_o,
   output logic                  rd_req_o,
   input  logic                  ready_i
);

   m6502_pkg::bus_state_e state_q;
   m6502_pkg::addr_mode_e mode_q;
   m6502_pkg::byte_t      lo_q;    // Address low byte
   m6502_pkg::byte_t      data_q;  // Last byte read
   logic                  store_q;

   assign vec_addr_o   = {data_q, lo_q};
   assign fetch_data_o = data_q;
   assign opnd_data_o  = data_q;

   always_ff @(posedge clk)
   begin
      vec_done_o   <= 1'b0;
      fetch_done_o <= 1'b0;
      opnd_done_o  <= 1'b0;
      if (!reset_n)
      begin
         state_q  <= m6502_pkg::BUS_IDLE;
         rd_req_o <= 1'b0;
         wr_en_o  <= 1'b0;
      end
      else if (state_q == m6502_pkg::BUS_IDLE)
      begin
         if (vec_start_i)
         begin
            addr_o   <= RESET_VECTOR;
            rd_req_o <= 1'b1;
            state_q  <= m6502_pkg::BUS_VEC_LO;
         end
         else if (fetch_start_i)
         begin
            addr_o   <= fetch_addr_i;
            rd_req_o <= 1'b1;
            state_q  <= m6502_pkg::BUS_FETCH;
         end
         else if (opnd_start_i)
         begin
            addr_o    <= opnd_pc_i;
            rd_req_o  <= 1'b1;
            mode_q    <= opnd_mode_i;
            store_q   <= opnd_store_i;
            wr_data_o <= store_data_i;
            state_q   <= m6502_pkg::BUS_OPND;
         end
      end
      else if (!rd_req_o && !wr_en_o)
      begin
         // Idle cycle is over, present the next access
         if (state_q == m6502_pkg::BUS_DATA && store_q)
            wr_en_o <= 1'b1;
         else
            rd_req_o <= 1'b1;
      end
      else if (ready_i)
      begin
         rd_req_o <= 1'b0;
         wr_en_o  <= 1'b0;
         case (state_q)
            m6502_pkg::BUS_VEC_LO:
            begin
               lo_q    <= rd_data_i;
               addr_o  <= addr_o + 16'd1;
               state_q <= m6502_pkg::BUS_VEC_HI;
            end
            m6502_pkg::BUS_OPND:
               if (mode_q == m6502_pkg::ZP)
               begin
                  addr_o  <= {8'h00, rd_data_i};
                  state_q <= m6502_pkg::BUS_DATA;
               end
               else if (mode_q == m6502_pkg::ABS)
               begin
                  lo_q    <= rd_data_i;
                  addr_o  <= addr_o + 16'd1;
                  state_q <= m6502_pkg::BUS_ADDR_HI;
               end
               else
               begin
                  data_q      <= rd_data_i;  // IMM and REL
                  opnd_done_o <= 1'b1;
                  state_q     <= m6502_pkg::BUS_IDLE;
               end
            m6502_pkg::BUS_ADDR_HI:
            begin
               addr_o  <= {rd_data_i, lo_q};
               state_q <= m6502_pkg::BUS_DATA;
            end
            default:
            begin
               // Final access of VEC_HI, FETCH or DATA
               data_q       <= rd_data_i;
               vec_done_o   <= (state_q == m6502_pkg::BUS_VEC_HI);
               fetch_done_o <= (state_q == m6502_pkg::BUS_FETCH);
               opnd_done_o  <= (state_q == m6502_pkg::BUS_DATA);
               state_q      <= m6502_pkg::BUS_IDLE;
            end
         endcase
      end
   end

endmodule

//--- verilog/m6502_cpu.sv
// --------------------------------------------------
// 6502-style core top level. Connect the memory port
// and set RESET_VECTOR to place the reset vector.
// --------------------------------------------------
module m6502_cpu #(
   parameter m6502_pkg::addr_t RESET_VECTOR = m6502_pkg::RESET_VECTOR_DEF
) (
   input  logic             clk,
   input  logic             reset_n,
   output m6502_pkg::addr_t addr_o,
   input  m6502_pkg::byte_t rd_data_i,
   output m6502_pkg::byte_t wr_data_o,
   output logic             wr_en_o,
   output logic             rd_req_o,
   input  logic             ready_i
);

   logic                  vec_start;
   logic                  vec_done;
   m6502_pkg::addr_t      vec_addr;
   logic                  fetch_start;
   m6502_pkg::addr_t      fetch_addr;
   logic                  fetch_done;
   m6502_pkg::byte_t      fetch_data;
   m6502_pkg::byte_t      opcode;
   m6502_pkg::cpu_op_e    dec_op;
   m6502_pkg::addr_mode_e dec_mode;
   logic [1:0]            dec_len;
   logic                  opnd_start;
   m6502_pkg::addr_mode_e opnd_mode;
   m6502_pkg::addr_t      opnd_pc;
   logic                  opnd_store;
   logic                  opnd_done;
   m6502_pkg::byte_t      opnd_data;
   logic                  alu_go;
   m6502_pkg::cpu_op_e    alu_op;
   m6502_pkg::byte_t      alu_operand;
   m6502_pkg::byte_t      acc;
   m6502_pkg::flags_t     flags;

   m6502_sequencer u_sequencer (
      .clk           (clk),
      .reset_n       (reset_n),
      .vec_start_o   (vec_start),
      .vec_done_i    (vec_done),
      .vec_addr_i    (vec_addr),
      .fetch_start_o (fetch_start),
      .fetch_addr_o  (fetch_addr),
      .fetch_done_i  (fetch_done),
      .fetch_data_i  (fetch_data),
      .opcode_o      (opcode),
      .dec_op_i      (dec_op),
      .dec_mode_i    (dec_mode),
      .dec_len_i     (dec_len),
      .opnd_start_o  (opnd_start),
      .opnd_mode_o   (opnd_mode),
      .opnd_pc_o     (opnd_pc),
      .opnd_store_o  (opnd_store),
      .opnd_done_i   (opnd_done),
      .opnd_data_i   (opnd_data),
      .alu_go_o      (alu_go),
      .alu_op_o      (alu_op),
      .alu_operand_o (alu_operand),
      .flags_i       (flags)
   );

   m6502_decoder u_decoder (
      .opcode_i (opcode),
      .op_o     (dec_op),
      .mode_o   (dec_mode),
      .len_o    (dec_len)
   );

   m6502_bus_ctrl #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_bus_ctrl (
      .clk           (clk),
      .reset_n       (reset_n),
      .vec_start_i   (vec_start),
      .vec_done_o    (vec_done),
      .vec_addr_o    (vec_addr),
      .fetch_start_i (fetch_start),
      .fetch_addr_i  (fetch_addr),
      .fetch_done_o  (fetch_done),
      .fetch_data_o  (fetch_data),
      .opnd_start_i  (opnd_start),
      .opnd_mode_i   (opnd_mode),
      .opnd_pc_i     (opnd_pc),
      .opnd_store_i  (opnd_store),
      .opnd_done_o   (opnd_done),
      .opnd_data_o   (opnd_data),
      .store_data_i  (acc),  // STA writes the accumulator
      .addr_o        (addr_o),
      .rd_data_i     (rd_data_i),
      .wr_data_o     (wr_data_o),
      .wr_en_o       (wr_en_o),
      .rd_req_o      (rd_req_o),
      .ready_i       (ready_i)
   );

   m6502_alu u_alu (
      .clk           (clk),
      .reset_n       (reset_n),
      .alu_go_i      (alu_go),
      .alu_op_i      (alu_op),
      .alu_operand_i (alu_operand),
      .acc_o         (acc),
      .flags_o       (flags)
   );

endmodule

//--- verilog/m6502_decoder.sv
// --------------------------------------------------
// Opcode decode into operation, addressing mode and
// instruction length. Purely combinational.
// --------------------------------------------------
module m6502_decoder (
   input  m6502_pkg::byte_t      opcode_i,
   output m6502_pkg::cpu_op_e    op_o,
   output m6502_pkg::addr_mode_e mode_o,
   output logic [1:0]            len_o
);

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;

   assign aaa = opcode_i[7:5];
   assign bbb = opcode_i[4:2];
   assign cc  = opcode_i[1:0];

   always_comb
   begin
      op_o   = m6502_pkg::NOP;
      mode_o = m6502_pkg::NONE;
      if (cc == 2'b01)  // Group one
      begin
         case (bbb)
            3'b001:  mode_o = m6502_pkg::ZP;
            3'b010:  mode_o = m6502_pkg::IMM;
            3'b011:  mode_o = m6502_pkg::ABS;
            default: mode_o = m6502_pkg::NONE;
         endcase
         case (aaa)
            3'b000:  op_o = m6502_pkg::ORA;
            3'b001:  op_o = m6502_pkg::AND;
            3'b010:  op_o = m6502_pkg::EOR;
            3'b011:  op_o = m6502_pkg::ADC;
            3'b100:  op_o = m6502_pkg::ST;
            3'b101:  op_o = m6502_pkg::LD;
            3'b110:  op_o = m6502_pkg::CMP;
            default: op_o = m6502_pkg::SBC;
         endcase
         // STA immediate has no target
         if (mode_o == m6502_pkg::NONE ||
             (op_o == m6502_pkg::ST && mode_o == m6502_pkg::IMM))
         begin
            op_o   = m6502_pkg::NOP;
            mode_o = m6502_pkg::NONE;
         end
      end
      else if (cc == 2'b00 && bbb == 3'b100)  // Branch column
      begin
         op_o   = m6502_pkg::BRANCH;
         mode_o = m6502_pkg::REL;
      end
   end

   always_comb
   begin
      case (mode_o)
         m6502_pkg::NONE: len_o = 2'd1;
         m6502_pkg::ABS:  len_o = 2'd3;
         default:         len_o = 2'd2;
      endcase
   end

endmodule

//--- verilog/m6502_pkg.sv
// --------------------------------------------------
// Shared widths, flag positions and enums of the
// 6502 core, referenced as m6502_pkg::name
// --------------------------------------------------
package m6502_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  flags_t;  // N, V, Z, C

   // Bit positions inside flags_t
   localparam int FLAG_N = 3;
   localparam int FLAG_V = 2;
   localparam int FLAG_Z = 1;
   localparam int FLAG_C = 0;

   localparam addr_t RESET_VECTOR_DEF = 16'hFFFC;  // Low byte of reset vector

   typedef enum logic [3:0] {
      NOP,
      ORA,
      AND,
      EOR,
      ADC,
      SBC,
      LD,
      CMP,
      ST,
      BRANCH
   } cpu_op_e;

   typedef enum logic [2:0] {
      NONE,
      IMM,
      ZP,
      ABS,
      REL
   } addr_mode_e;

   typedef enum logic [2:0] {
      SEQ_VECTOR,
      SEQ_FETCH,
      SEQ_OPERAND,
      SEQ_EXECUTE,
      SEQ_NEXT
   } seq_state_e;

   typedef enum logic [2:0] {
      BUS_IDLE,
      BUS_VEC_LO,
      BUS_VEC_HI,
      BUS_FETCH,
      BUS_OPND,
      BUS_ADDR_HI,
      BUS_DATA
   } bus_state_e;

endpackage

//--- verilog/m6502_sequencer.sv
// --------------------------------------------------
// Instruction sequencer: PC, instruction register,
// bus phase requests, ALU hand-off and branch logic
// --------------------------------------------------
module m6502_sequencer (
   input  logic                  clk,
   input  logic                  reset_n,
   output logic                  vec_start_o,
   input  logic                  vec_done_i,
   input  m6502_pkg::addr_t      vec_addr_i,
   output logic                  fetch_start_o,
   output m6502_pkg::addr_t      fetch_addr_o,
   input  logic                  fetch_done_i,
   input  m6502_pkg::byte_t      fetch_data_i,
   output m6502_pkg::byte_t      opcode_o,
   input  m6502_pkg::cpu_op_e    dec_op_i,
   input  m6502_pkg::addr_mode_e dec_mode_i,
   input  logic [1:0]            dec_len_i,
   output logic                  opnd_start_o,
   output m6502_pkg::addr_mode_e opnd_mode_o,
   output m6502_pkg::addr_t      opnd_pc_o,
   output logic                  opnd_store_o,
   input  logic                  opnd_done_i,
   input  m6502_pkg::byte_t      opnd_data_i,
   output logic                  alu_go_o,
   output m6502_pkg::cpu_op_e    alu_op_o,
   output m6502_pkg::byte_t      alu_operand_o,
   input  m6502_pkg::flags_t     flags_i
);

   m6502_pkg::seq_state_e state_q;
   m6502_pkg::addr_t      pc_q;
   m6502_pkg::addr_t      pc_next;
   m6502_pkg::addr_t      offset;
   m6502_pkg::byte_t      ir_q;
   m6502_pkg::byte_t      operand_q;
   logic                  flag_sel;
   logic                  take;

   // Decode the arriving opcode so the operand request leaves on the same edge
   assign opcode_o = (state_q == m6502_pkg::SEQ_FETCH && fetch_done_i) ?
                     fetch_data_i : ir_q;

   assign fetch_addr_o  = pc_q;
   assign opnd_pc_o     = pc_q + 16'd1;
   assign opnd_mode_o   = dec_mode_i;
   assign opnd_store_o  = (dec_op_i == m6502_pkg::ST);
   assign alu_op_o      = dec_op_i;
   assign alu_operand_o = operand_q;
   assign pc_next       = pc_q + {14'd0, dec_len_i};

   // Opcode bits 7:6 pick the flag, bit 5 the value that takes the branch
   always_comb
   begin
      case (ir_q[7:6])
         2'b00:   flag_sel = flags_i[m6502_pkg::FLAG_N];
         2'b01:   flag_sel = flags_i[m6502_pkg::FLAG_V];
         2'b10:   flag_sel = flags_i[m6502_pkg::FLAG_C];
         default: flag_sel = flags_i[m6502_pkg::FLAG_Z];
      endcase
   end

   assign take   = (flag_sel == ir_q[5]);
   assign offset = take ? {{8{opnd_data_i[7]}}, opnd_data_i} : 16'd0;

   always_ff @(posedge clk)
   begin
      vec_start_o   <= 1'b0;
      fetch_start_o <= 1'b0;
      opnd_start_o  <= 1'b0;
      alu_go_o      <= 1'b0;
      if (!reset_n)
      begin
         state_q     <= m6502_pkg::SEQ_VECTOR;
         vec_start_o <= 1'b1;  // Vector read goes out as reset releases
      end
      else
      begin
         case (state_q)
            m6502_pkg::SEQ_VECTOR:
               if (vec_done_i)
               begin
                  pc_q    <= vec_addr_i;
                  state_q <= m6502_pkg::SEQ_NEXT;
               end
            m6502_pkg::SEQ_FETCH:
               if (fetch_done_i)
               begin
                  ir_q <= fetch_data_i;
                  if (dec_mode_i == m6502_pkg::NONE)
                  begin
                     pc_q    <= pc_next;  // One-byte no-op
                     state_q <= m6502_pkg::SEQ_NEXT;
                  end
                  else
                  begin
                     opnd_start_o <= 1'b1;
                     state_q      <= m6502_pkg::SEQ_OPERAND;
                  end
               end
            m6502_pkg::SEQ_OPERAND:
               if (opnd_done_i)
               begin
                  operand_q <= opnd_data_i;
                  if (dec_op_i == m6502_pkg::BRANCH)
                  begin
                     pc_q    <= pc_next + offset;
                     state_q <= m6502_pkg::SEQ_NEXT;
                  end
                  else
                  begin
                     pc_q     <= pc_next;
                     alu_go_o <= 1'b1;
                     state_q  <= m6502_pkg::SEQ_EXECUTE;
                  end
               end
            default:
            begin
               // ALU writes back during EXECUTE while the next fetch is requested
               fetch_start_o <= 1'b1;
               state_q       <= m6502_pkg::SEQ_FETCH;
            end
         endcase
      end
   end

endmodule
